// File: dv/window_filter_checker.sv
// Window filter checker
// watches the DUT ports, recomputes each 2x2 floor average from the
// current image and tracks read coverage and write order per frame

module window_filter_checker
#(
	parameter int IMG_W = 8,
	parameter int IMG_H = 6
)
(
	input  logic clk,
	input  logic n_rst,
	input  logic start_i,
	input  win_pkg::pixel_t img_i [IMG_W*IMG_H], // image of the running frame
	input  logic mem_rd_req_i,
	input  win_pkg::addr_t mem_rd_addr_i,
	input  logic mem_wr_en_i,
	input  win_pkg::addr_t mem_wr_addr_i,
	input  win_pkg::pixel_t mem_wr_data_i,
	input  logic done_i,
	output int chk_cnt_o,
	output int err_cnt_o,
	output int frame_cnt_o
);
	timeunit 1ns;
	timeprecision 1ps;
	import win_pkg::*;

	localparam int N_PIX = IMG_W * IMG_H;
	localparam int N_OUT = (IMG_W - 1) * (IMG_H - 1);

	int rd_cnt [N_PIX]; // reads per input pixel, this frame
	int next_wr; // next expected output address
	int chk_cnt;
	int err_cnt;
	int frame_cnt;
	bit seen_start;
	bit wr_prev; // write seen last cycle
	bit done_prev;

	assign chk_cnt_o = chk_cnt;
	assign err_cnt_o = err_cnt;
	assign frame_cnt_o = frame_cnt;

	// output a covers rows r, r+1 and columns c, c+1 of the input
	function automatic pixel_t ref_avg(input int a);
		int r;
		int c;
		int s;
		r = a / (IMG_W - 1);
		c = a % (IMG_W - 1);
		s = int'(img_i[r*IMG_W + c]) + int'(img_i[r*IMG_W + c + 1])
			+ int'(img_i[(r+1)*IMG_W + c]) + int'(img_i[(r+1)*IMG_W + c + 1]);
		return pixel_t'(s / 4); // floor, sum never negative
	endfunction

	task automatic check_idle();
		chk_cnt++;
		if (mem_rd_req_i || mem_wr_en_i || done_i)
		begin
			err_cnt++;
			$display("Fail idle_outputs: expected 000, actual %b%b%b",
				mem_rd_req_i, mem_wr_en_i, done_i);
		end
	endtask

	task automatic log_read();
		int a;
		a = int'(mem_rd_addr_i);
		chk_cnt++;
		if (a >= N_PIX)
		begin
			err_cnt++;
			$display("Error: read address %0d lies outside the %0d pixel frame", a, N_PIX);
		end
		else
			rd_cnt[a] = rd_cnt[a] + 1;
	endtask

	task automatic check_write();
		int     a;
		pixel_t exp_pix;
		a = int'(mem_wr_addr_i);
		chk_cnt++;
		if (a != next_wr)
		begin
			err_cnt++;
			$display("Fail wr_order frame %0d: expected %0d, actual %0d", frame_cnt, next_wr, a);
		end
		chk_cnt++;
		if (a >= N_OUT)
		begin
			err_cnt++;
			$display("Error: write address %0d lies beyond the output image", a);
		end
		else
		begin
			exp_pix = ref_avg(a);
			if (mem_wr_data_i !== exp_pix)
			begin
				err_cnt++;
				$display("Fail avg_value frame %0d addr %0d: expected %0d, actual %0d",
					frame_cnt, a, exp_pix, mem_wr_data_i);
			end
		end
		next_wr++;
	endtask

	task automatic check_frame_end();
		int i;
		chk_cnt++;
		if (done_prev)
		begin
			err_cnt++;
			$display("Error: done_o stayed high for more than one cycle");
		end
		chk_cnt++;
		if (!wr_prev)
		begin
			err_cnt++;
			$display("Error: done_o did not come one cycle after the last write");
		end
		chk_cnt++;
		if (next_wr != N_OUT)
		begin
			err_cnt++;
			$display("Fail wr_count frame %0d: expected %0d, actual %0d", frame_cnt, N_OUT, next_wr);
		end
		for (i = 0; i < N_PIX; i++)
		begin
			chk_cnt++;
			if (rd_cnt[i] != 1)
			begin
				err_cnt++;
				$display("Fail rd_once frame %0d pixel %0d: expected 1, actual %0d",
					frame_cnt, i, rd_cnt[i]);
			end
			rd_cnt[i] = 0; // fresh count for the next frame
		end
		next_wr = 0;
		frame_cnt++;
	endtask

	initial
	begin
		chk_cnt = 0;
		err_cnt = 0;
		frame_cnt = 0;
		next_wr = 0;
		seen_start = 1'b0;
		wr_prev = 1'b0;
		done_prev = 1'b0;
		foreach (rd_cnt[i])
			rd_cnt[i] = 0;
	end

	// outputs are sampled as they stood before the edge
	always @(posedge clk)
	begin
		if (!seen_start)
			check_idle(); // reset and idle, nothing may move
		if (n_rst && start_i)
			seen_start = 1'b1;
		if (n_rst)
		begin
			if (mem_rd_req_i)
				log_read();
			if (mem_wr_en_i)
				check_write();
			if (done_i)
				check_frame_end();
			wr_prev = mem_wr_en_i;
			done_prev = done_i;
		end
	end

endmodule

// File: dv/window_filter_tb.sv
// Window filter testbench
// clock, reset, pixel memory with random read latency, two frames
// of random images and a watchdog

module window_filter_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import win_pkg::*;

	localparam int IMG_W = DEF_IMG_W;
	localparam int IMG_H = DEF_IMG_H;
	localparam int FRAMES = 2;
	localparam int RST_CYCLES = 10;
	localparam int WATCHDOG_NS = FRAMES * IMG_W * IMG_H * 12 * 10; // 12 cycles per pixel

	logic   clk = 1'b0;
	logic   n_rst;
	logic   start;
	logic   rd_valid;
	pixel_t rd_data;
	logic   rd_req;
	addr_t  rd_addr;
	logic   wr_en;
	addr_t  wr_addr;
	pixel_t wr_data;
	logic   done;

	pixel_t img [IMG_W*IMG_H]; // pixel memory contents
	int     seed = 16;
	int     chk_cnt;
	int     err_cnt;
	int     frame_cnt;

	always #5 clk = ~clk; // 10 ns period

	window_filter_top #(.IMG_W(IMG_W), .IMG_H(IMG_H)) dut_i (
		.clk(clk),
		.n_rst(n_rst),
		.start_i(start),
		.mem_rd_valid_i(rd_valid),
		.mem_rd_data_i(rd_data),
		.mem_rd_req_o(rd_req),
		.mem_rd_addr_o(rd_addr),
		.mem_wr_en_o(wr_en),
		.mem_wr_addr_o(wr_addr),
		.mem_wr_data_o(wr_data),
		.done_o(done)
	);

	window_filter_checker #(.IMG_W(IMG_W), .IMG_H(IMG_H)) chk_i (
		.clk(clk),
		.n_rst(n_rst),
		.start_i(start),
		.img_i(img),
		.mem_rd_req_i(rd_req),
		.mem_rd_addr_i(rd_addr),
		.mem_wr_en_i(wr_en),
		.mem_wr_addr_i(wr_addr),
		.mem_wr_data_i(wr_data),
		.done_i(done),
		.chk_cnt_o(chk_cnt),
		.err_cnt_o(err_cnt),
		.frame_cnt_o(frame_cnt)
	);

	function automatic pixel_t read_pixel(input addr_t a);
		if (int'(a) < IMG_W * IMG_H)
			return img[int'(a)];
		return 8'h00; // out of range, the checker flags it
	endfunction

	task automatic fill_image();
		int i;
		for (i = 0; i < IMG_W * IMG_H; i++)
			img[i] = pixel_t'($random(seed));
	endtask

	// start pulse, optional start while busy, then wait for done
	task automatic run_frame(input bit poke_busy);
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (poke_busy)
		begin
			repeat (20) @(negedge clk);
			start = 1'b1; // must be ignored mid frame
			@(negedge clk);
			start = 1'b0;
		end
		while (!done)
			@(negedge clk);
	endtask

	// one read in flight, answered 1 to 4 cycles after the request
	initial
	begin : mem_model
		int    lat_left;
		bit    pending;
		addr_t req_addr;
		rd_valid = 1'b0;
		rd_data = '0;
		lat_left = 0;
		pending = 1'b0;
		req_addr = '0;
		forever
		begin
			@(negedge clk);
			rd_valid = 1'b0;
			rd_data = 8'ha5; // junk between answers
			if (pending)
			begin
				lat_left = lat_left - 1;
				if (lat_left == 0)
				begin
					rd_valid = 1'b1;
					rd_data = read_pixel(req_addr);
					pending = 1'b0;
				end
			end
			if (rd_req)
			begin
				pending = 1'b1;
				req_addr = rd_addr;
				lat_left = 1 + ($random(seed) & 3);
			end
		end
	end

	initial
	begin : main
		int f;
		n_rst = 1'b0;
		start = 1'b0;
		repeat (RST_CYCLES) @(negedge clk);
		n_rst = 1'b1;
		repeat (4) @(negedge clk); // quiet without start
		for (f = 0; f < FRAMES; f++)
		begin
			fill_image(); // new image every frame
			run_frame(f > 0);
		end
		@(negedge clk);
		$display("checks %0d, errors %0d, frames %0d of %0d", chk_cnt, err_cnt, frame_cnt, FRAMES);
		if (err_cnt == 0 && frame_cnt == FRAMES)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial
	begin : watchdog
		#(WATCHDOG_NS);
		$display("Error: timeout after %0d ns, the frames did not all finish", WATCHDOG_NS);
		$display("Regression failed");
		$finish;
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the 2x2 window filter regression with Verilator

cd "$(dirname "$0")" || exit 1

TOP=window_filter_tb
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module "$TOP" -f sources.f -o sim_bin
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_bin > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: sources.f
verilog/win_pkg.sv
verilog/win_ctrl_if.sv
verilog/frame_ctrl.sv
verilog/pixel_addr_gen.sv
verilog/row_cache.sv
verilog/window_buf.sv
verilog/window_filter_top.sv
dv/window_filter_checker.sv
dv/window_filter_tb.sv

// File: verilog/frame_ctrl.sv
// Frame sequencing FSM
// fills the row cache with row 0, then for each later row loads the
// left window column and walks the remaining columns writing averages

module frame_ctrl
(
	input  logic clk,
	input  logic n_rst,
	input  logic start_i, // ignored unless idle
	input  logic mem_rd_valid_i,
	input  logic col_last_i,
	input  logic row_last_i,
	input  logic col_zero_i,
	output logic mem_rd_req_o,
	output logic mem_wr_en_o,
	output logic done_o,
	win_ctrl_if.ctrl ctl
);
	import win_pkg::*;

	typedef enum logic [3:0] {
		st_idle,
		st_fill_req, // row 0 pixel request
		st_fill_wait, // single wait state per read
		st_fill_wr, // pixel into row cache
		st_col_req, // pixel request plus cache read of upper row
		st_col_top, // upper pixel into top slot
		st_col_wait, // memory still busy
		st_col_cap, // lower pixel into bottom slot and cache
		st_col_out, // average out, window shift
		st_done
	} state_e;

	state_e state, next_state;
	logic   rd_pending; // memory read in flight

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (n_rst == 1'b0)
		begin
			state <= st_idle;
			rd_pending <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (mem_rd_req_o)
				rd_pending <= 1'b1;
			else if (mem_rd_valid_i)
				rd_pending <= 1'b0;
		end
	end

	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:      if (start_i) next_state = st_fill_req;
			st_fill_req:  next_state = st_fill_wait;
			st_fill_wait: if (mem_rd_valid_i) next_state = st_fill_wr;
			st_fill_wr:   next_state = col_last_i ? st_col_req : st_fill_req; // row 0 done
			st_col_req:   next_state = st_col_top;
			st_col_top:   next_state = mem_rd_valid_i ? st_col_cap : st_col_wait; // latency 1
			st_col_wait:  if (mem_rd_valid_i) next_state = st_col_cap;
			st_col_cap:   next_state = col_zero_i ? st_col_req : st_col_out; // left column only
			st_col_out:
			begin
				if (col_last_i)
					next_state = row_last_i ? st_done : st_col_req;
				else
					next_state = st_col_req;
			end
			st_done:      next_state = st_idle;
			default:      next_state = st_idle;
		endcase
	end

	// strobes decoded from state
	always_comb
	begin
		mem_rd_req_o = 1'b0;
		mem_wr_en_o = 1'b0;
		done_o = 1'b0;
		ctl.wb_load = 1'b0;
		ctl.wb_slot = top_left;
		ctl.wb_shift = 1'b0;
		ctl.cache_rd = 1'b0;
		ctl.cache_wr = 1'b0;
		ctl.col_adv = 1'b0;
		ctl.row_adv = 1'b0;
		ctl.out_adv = 1'b0;
		case (state)
			st_fill_req: mem_rd_req_o = 1'b1;
			st_fill_wr:
			begin
				ctl.cache_wr = 1'b1;
				ctl.col_adv = 1'b1; // rolls over at last column
				ctl.row_adv = col_last_i;
			end
			st_col_req:
			begin
				mem_rd_req_o = 1'b1;
				ctl.cache_rd = 1'b1; // upper row pixel, same column
			end
			st_col_top:
			begin
				ctl.wb_load = 1'b1;
				ctl.wb_slot = col_zero_i ? top_left : top_right;
			end
			st_col_cap:
			begin
				ctl.wb_load = 1'b1;
				ctl.wb_slot = col_zero_i ? bot_left : bot_right;
				ctl.cache_wr = 1'b1; // overwrite upper pixel, already read
				ctl.col_adv = col_zero_i; // later columns step in st_col_out
			end
			st_col_out:
			begin
				mem_wr_en_o = 1'b1;
				ctl.wb_shift = 1'b1;
				ctl.out_adv = 1'b1;
				ctl.col_adv = 1'b1;
				ctl.row_adv = col_last_i; // last row rolls the frame over
			end
			st_done: done_o = 1'b1; // one cycle after last write
			default: ;
		endcase
	end

	// one read outstanding at a time
	a_one_read: assert property (@(posedge clk) disable iff (!n_rst)
		mem_rd_req_o |-> !rd_pending);

endmodule

// File: verilog/pixel_addr_gen.sv
// Pixel address generator
// column and row counters with rollover, read address from the
// row base plus column, and a running output address

module pixel_addr_gen
#(
	parameter int IMG_W = 8,
	parameter int IMG_H = 6
)
(
	input  logic clk,
	input  logic n_rst,
	win_ctrl_if.addr ctl,
	output win_pkg::addr_t col_o,
	output win_pkg::addr_t rd_addr_o,
	output win_pkg::addr_t wr_addr_o,
	output logic col_last_o,
	output logic row_last_o,
	output logic col_zero_o
);
	import win_pkg::*;

	addr_t col_q; // current column
	addr_t row_q; // current row
	addr_t row_base_q; // row times IMG_W, kept as a running sum
	addr_t wr_q; // next output pixel

	assign col_last_o = (col_q == addr_t'(IMG_W - 1));
	assign row_last_o = (row_q == addr_t'(IMG_H - 1));
	assign col_zero_o = (col_q == '0);

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (n_rst == 1'b0)
		begin
			col_q <= '0;
			row_q <= '0;
			row_base_q <= '0;
			wr_q <= '0;
		end
		else
		begin
			if (ctl.col_adv)
				col_q <= col_last_o ? '0 : col_q + 1'b1; // column rollover
			if (ctl.row_adv)
			begin
				row_q <= row_last_o ? '0 : row_q + 1'b1; // frame rollover
				row_base_q <= row_last_o ? '0 : row_base_q + addr_t'(IMG_W);
			end
			if (ctl.row_adv && row_last_o)
				wr_q <= '0; // next frame starts at output 0
			else if (ctl.out_adv)
				wr_q <= wr_q + 1'b1;
		end
	end

	assign col_o = col_q;
	assign rd_addr_o = row_base_q + col_q;
	assign wr_addr_o = wr_q;

	a_rd_range: assert property (@(posedge clk) disable iff (!n_rst)
		int'(rd_addr_o) < IMG_W * IMG_H);

endmodule

// File: verilog/row_cache.sv
// Row cache
// one image row of pixels, written at the current column with the
// pixel just returned by memory, read back one cycle after cache_rd

module row_cache
#(
	parameter int IMG_W = 8
)
(
	input  logic clk,
	input  logic n_rst,
	input  win_pkg::addr_t col_i,
	input  win_pkg::pixel_t wr_data_i, // raw memory read data
	win_ctrl_if.cache ctl,
	output win_pkg::pixel_t rd_data_o
);
	import win_pkg::*;

	localparam int COL_W = (IMG_W > 1) ? $clog2(IMG_W) : 1;

	pixel_t           mem [IMG_W];
	pixel_t           pix_q; // memory data, one cycle late
	logic [COL_W-1:0] idx;

	assign idx = col_i[COL_W-1:0];

	// pix_q holds the returned pixel in the cycle after valid
	always_ff @(posedge clk)
	begin
		pix_q <= wr_data_i;
		if (ctl.cache_wr)
			mem[idx] <= pix_q;
	end

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (n_rst == 1'b0)
			rd_data_o <= '0;
		else if (ctl.cache_rd)
			rd_data_o <= mem[idx]; // upper row pixel
	end

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!n_rst)
		!(ctl.cache_rd && ctl.cache_wr));

endmodule

// File: verilog/win_ctrl_if.sv
// Controller to datapath strobes
// one-cycle pulses from the frame FSM to window, cache and counters

interface win_ctrl_if;
	import win_pkg::*;

	logic     wb_load; // load one window slot
	wb_slot_e wb_slot; // which slot wb_load targets
	logic     wb_shift; // right column moves to left column
	logic     cache_rd; // registered row cache read
	logic     cache_wr; // row cache write of captured pixel
	logic     col_adv; // column counter step
	logic     row_adv; // row counter step
	logic     out_adv; // output address step

	modport ctrl (output wb_load, wb_slot, wb_shift, cache_rd, cache_wr,
		col_adv, row_adv, out_adv);
	modport win (input wb_load, wb_slot, wb_shift);
	modport cache (input cache_rd, cache_wr);
	modport addr (input col_adv, row_adv, out_adv);

endinterface

// File: verilog/win_pkg.sv
// Window filter shared types
// pixel, pixel sum, memory address and window slot select,
// plus the default frame size used by the top level

package win_pkg;

	parameter int ADDR_W = 16; // pixel memory address width

	parameter int DEF_IMG_W = 8; // default frame width
	parameter int DEF_IMG_H = 6; // default frame height

	typedef logic [7:0] pixel_t; // one 8-bit pixel
	typedef logic [9:0] pix_sum_t; // four pixels summed, no overflow
	typedef logic [ADDR_W-1:0] addr_t; // pixel memory address

	// window register targeted by a load
	//   | top_left | top_right |
	//   | bot_left | bot_right |
	typedef enum logic [1:0] {
		top_left  = 2'd0, // filled from row cache
		top_right = 2'd1, // filled from row cache
		bot_left  = 2'd2, // filled from captured memory pixel
		bot_right = 2'd3  // filled from captured memory pixel
	} wb_slot_e;

endpackage

// File: verilog/window_buf.sv
// 2x2 window buffer
// top slots load from the row cache, bottom slots from the captured
// memory pixel; shift moves right column left, average is combinational

module window_buf
(
	input  logic clk,
	input  logic n_rst,
	input  win_pkg::pixel_t mem_data_i,
	input  logic mem_valid_i,
	input  win_pkg::pixel_t cache_data_i,
	win_ctrl_if.win ctl,
	output win_pkg::pixel_t avg_o
);
	import win_pkg::*;

	pixel_t   tl_q, tr_q, bl_q, br_q; // window registers
	pixel_t   cap_q; // captured memory pixel
	pix_sum_t sum;

	always_ff @(posedge clk)
	begin
		if (mem_valid_i)
			cap_q <= mem_data_i;
	end

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (n_rst == 1'b0)
		begin
			tl_q <= '0;
			tr_q <= '0;
			bl_q <= '0;
			br_q <= '0;
		end
		else if (ctl.wb_shift)
		begin
			tl_q <= tr_q; // right column becomes left
			bl_q <= br_q;
		end
		else if (ctl.wb_load)
		begin
			case (ctl.wb_slot)
				top_left:  tl_q <= cache_data_i;
				top_right: tr_q <= cache_data_i;
				bot_left:  bl_q <= cap_q;
				bot_right: br_q <= cap_q;
				default: ;
			endcase
		end
	end

	assign sum = pix_sum_t'(tl_q) + pix_sum_t'(tr_q) + pix_sum_t'(bl_q) + pix_sum_t'(br_q);
	assign avg_o = sum[9:2]; // divide by four, rounded down

endmodule

// File: verilog/window_filter_top.sv
// 2x2 window filter top level
// reads a frame from pixel memory and writes the floor average of
// every 2x2 neighbourhood to a (W-1) x (H-1) output image

module window_filter_top
#(
	parameter int IMG_W = win_pkg::DEF_IMG_W,
	parameter int IMG_H = win_pkg::DEF_IMG_H
)
(
	input  logic clk,
	input  logic n_rst,
	input  logic start_i,
	input  logic mem_rd_valid_i,
	input  win_pkg::pixel_t mem_rd_data_i,
	output logic mem_rd_req_o,
	output win_pkg::addr_t mem_rd_addr_o,
	output logic mem_wr_en_o,
	output win_pkg::addr_t mem_wr_addr_o,
	output win_pkg::pixel_t mem_wr_data_o,
	output logic done_o
);
	import win_pkg::*;

	win_ctrl_if ctl_if ();

	addr_t  col; // current column, row cache index
	pixel_t cache_data; // upper row pixel
	logic   col_last;
	logic   row_last;
	logic   col_zero;

	frame_ctrl ctrl_i (
		.clk(clk),
		.n_rst(n_rst),
		.start_i(start_i),
		.mem_rd_valid_i(mem_rd_valid_i),
		.col_last_i(col_last),
		.row_last_i(row_last),
		.col_zero_i(col_zero),
		.mem_rd_req_o(mem_rd_req_o),
		.mem_wr_en_o(mem_wr_en_o),
		.done_o(done_o),
		.ctl(ctl_if.ctrl)
	);

	pixel_addr_gen #(.IMG_W(IMG_W), .IMG_H(IMG_H)) addr_i (
		.clk(clk),
		.n_rst(n_rst),
		.ctl(ctl_if.addr),
		.col_o(col),
		.rd_addr_o(mem_rd_addr_o),
		.wr_addr_o(mem_wr_addr_o),
		.col_last_o(col_last),
		.row_last_o(row_last),
		.col_zero_o(col_zero)
	);

	row_cache #(.IMG_W(IMG_W)) cache_i (
		.clk(clk),
		.n_rst(n_rst),
		.col_i(col),
		.wr_data_i(mem_rd_data_i), // delayed internally to the capture cycle
		.ctl(ctl_if.cache),
		.rd_data_o(cache_data)
	);

	window_buf wbuf_i (
		.clk(clk),
		.n_rst(n_rst),
		.mem_data_i(mem_rd_data_i),
		.mem_valid_i(mem_rd_valid_i),
		.cache_data_i(cache_data),
		.ctl(ctl_if.win),
		.avg_o(mem_wr_data_o) // written straight to memory
	);

endmodule
